/* icache_miss_unit.f */
+incdir+src
src/ccu_pkg.sv
src/ifq_pkg.sv
src/ifq_entry.sv
src/ifq_queue_ctrl.sv
src/ifq.sv
src/ccu_line_reader.sv
src/icache_miss_unit.sv
testbench/tb_clkgen.sv
testbench/icache_miss_unit_chk.sv
testbench/tb_checker.sv
testbench/tb_icache_miss_unit.sv

/* src/ccu_line_reader.sv */
// Line reader that breaks a line read into word beats on the memory bus and rebuilds the line
`timescale 1ns/100ps
`include "icache_consts.svh"

module ccu_line_reader (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_line_req_valid,
    input  ifq_pkg::line_addr_t    i_line_req_addr,
    output logic                   o_line_req_ready,
    output logic                   o_line_done,
    output logic [`LINE_WIDTH-1:0] o_line_data,
    output logic                   o_mem_req_valid,
    output ccu_pkg::mem_req_t      o_mem_req,
    input  logic                   i_mem_req_ready,
    input  logic                   i_mem_rsp_valid,
    input  ccu_pkg::mem_rsp_t      i_mem_rsp
);

    localparam int BEAT_WIDTH = (`LINE_BEATS > 1) ? $clog2(`LINE_BEATS) : 1;
    localparam int BYTE_SHIFT = $clog2(`WORD_WIDTH / 8);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t                                 state;
    state_t                                 state_next;
    logic [BEAT_WIDTH-1:0]                  beat;
    logic                                   last_beat;
    logic                                   rsp_fire;
    ifq_pkg::line_addr_t                    line_base;
    logic [`ADDR_WIDTH-1:0]                 beat_offset;
    logic [`LINE_BEATS-1:0][`WORD_WIDTH-1:0] line_buf;
    logic [`LINE_BEATS-1:0][`WORD_WIDTH-1:0] line_words;

    assign o_line_req_ready = (state == ST_IDLE);
    assign o_mem_req_valid  = (state == ST_REQ);
    assign rsp_fire         = (state == ST_WAIT) & i_mem_rsp_valid;
    assign last_beat        = (beat == BEAT_WIDTH'(`LINE_BEATS - 1));
    assign o_line_done      = rsp_fire & last_beat;

    // Word address is line base plus beat times word size
    always_comb begin
        beat_offset = '0;
        beat_offset[BYTE_SHIFT +: BEAT_WIDTH] = beat;
    end
    assign o_mem_req.addr = {line_base, {`LINE_OFFSET_WIDTH{1'b0}}} + beat_offset;

    // Last word bypasses the buffer so done carries the whole line
    always_comb begin
        line_words       = line_buf;
        line_words[beat] = i_mem_rsp.data;
        o_line_data      = line_words;
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (i_line_req_valid) state_next = ST_REQ;
            ST_REQ:  if (i_mem_req_ready) state_next = ST_WAIT;
            ST_WAIT: if (i_mem_rsp_valid) state_next = last_beat ? ST_IDLE : ST_REQ;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            beat  <= '0;
        end else begin
            state <= state_next;
            if (o_line_req_ready) begin
                beat <= '0;
            end else if (rsp_fire && !last_beat) begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_line_req_ready && i_line_req_valid) begin
            line_base <= i_line_req_addr;
        end
        if (rsp_fire) begin
            line_buf[beat] <= i_mem_rsp.data;
        end
    end

endmodule

/* src/ccu_pkg.sv */
// Memory-side transfer types shared by the line reader and the memory bus
`include "icache_consts.svh"

package ccu_pkg;

    // One word read request carrying the byte address of the word
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    // One word of read data returned by memory
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

/* src/icache_consts.svh */
// Build-time sizes for the instruction-cache miss path, included by packages and RTL
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Byte address width
`define ADDR_WIDTH 32

// Memory bus data width
`define WORD_WIDTH 32

// Words per cache line
`define LINE_BEATS 4

// Full line width in bits
`define LINE_WIDTH (`LINE_BEATS * `WORD_WIDTH)

// Byte offset bits within a line
`define LINE_OFFSET_WIDTH 4

// Outstanding miss slots in the fetch queue
`define IFQ_DEPTH 4

`endif

/* src/icache_miss_unit.sv */
// Top of the instruction-cache miss path, joins the fetch queue to the line reader
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_miss_unit (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_alloc_valid,
    input  ifq_pkg::ifq_alloc_t i_alloc,
    output logic                o_alloc_ready,
    output logic                o_fill_valid,
    output ifq_pkg::ifq_fill_t  o_fill,
    output logic                o_mem_req_valid,
    output ccu_pkg::mem_req_t   o_mem_req,
    input  logic                i_mem_req_ready,
    input  logic                i_mem_rsp_valid,
    input  ccu_pkg::mem_rsp_t   i_mem_rsp
);

    logic                   line_req_valid;
    logic                   line_req_ready;
    ifq_pkg::line_addr_t    line_req_addr;
    logic                   line_done;
    logic [`LINE_WIDTH-1:0] line_data;

    ifq u_ifq (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_alloc_valid    (i_alloc_valid),
        .i_alloc          (i_alloc),
        .o_alloc_ready    (o_alloc_ready),
        .o_fill_valid     (o_fill_valid),
        .o_fill           (o_fill),
        .o_line_req_valid (line_req_valid),
        .o_line_req_addr  (line_req_addr),
        .i_line_req_ready (line_req_ready),
        .i_line_done      (line_done),
        .i_line_data      (line_data)
    );

    ccu_line_reader u_line_reader (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_line_req_valid (line_req_valid),
        .i_line_req_addr  (line_req_addr),
        .o_line_req_ready (line_req_ready),
        .o_line_done      (line_done),
        .o_line_data      (line_data),
        .o_mem_req_valid  (o_mem_req_valid),
        .o_mem_req        (o_mem_req),
        .i_mem_req_ready  (i_mem_req_ready),
        .i_mem_rsp_valid  (i_mem_rsp_valid),
        .i_mem_rsp        (i_mem_rsp)
    );

endmodule

/* src/ifq.sv */
// Instruction fetch queue that takes miss allocations, issues the oldest and fills the cache
`timescale 1ns/100ps
`include "icache_consts.svh"

module ifq (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_alloc_valid,
    input  ifq_pkg::ifq_alloc_t    i_alloc,
    output logic                   o_alloc_ready,
    output logic                   o_fill_valid,
    output ifq_pkg::ifq_fill_t     o_fill,
    output logic                   o_line_req_valid,
    output ifq_pkg::line_addr_t    o_line_req_addr,
    input  logic                   i_line_req_ready,
    input  logic                   i_line_done,
    input  logic [`LINE_WIDTH-1:0] i_line_data
);

    localparam int IDX_WIDTH = (`IFQ_DEPTH > 1) ? $clog2(`IFQ_DEPTH) : 1;

    logic [IDX_WIDTH-1:0]  queue_head;
    logic [IDX_WIDTH-1:0]  queue_tail;
    logic                  queue_full;
    logic                  queue_empty;
    logic                  alloc_fire;
    logic                  line_busy;
    logic                  line_pop;
    logic [`IFQ_DEPTH-1:0] alloc_sel;
    logic [`IFQ_DEPTH-1:0] clear_sel;
    logic [`IFQ_DEPTH-1:0] entry_valid;
    ifq_pkg::line_addr_t   entry_addr [`IFQ_DEPTH];
    ifq_pkg::line_addr_t   alloc_line;

    assign o_alloc_ready = ~queue_full;
    assign alloc_fire    = i_alloc_valid & o_alloc_ready;
    assign alloc_line    = i_alloc.addr[`ADDR_WIDTH-1:`LINE_OFFSET_WIDTH];

    // Only a done for a line this queue handed out retires the head
    assign line_pop = i_line_done & line_busy & ~queue_empty;

    // One-hot write select from tail, one-hot clear from head
    always_comb begin
        alloc_sel = '0;
        clear_sel = '0;
        alloc_sel[queue_tail] = alloc_fire;
        clear_sel[queue_head] = line_pop;
    end

    for (genvar i = 0; i < `IFQ_DEPTH; i++) begin : g_entry
        ifq_entry u_entry (
            .clk          (clk),
            .i_rst_n      (i_rst_n),
            .i_alloc_en   (alloc_sel[i]),
            .i_alloc_addr (alloc_line),
            .i_clear      (clear_sel[i]),
            .o_valid      (entry_valid[i]),
            .o_addr       (entry_addr[i])
        );
    end

    ifq_queue_ctrl #(
        .DEPTH (`IFQ_DEPTH)
    ) u_queue_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_incr_head (line_pop),
        .i_incr_tail (alloc_fire),
        .o_head      (queue_head),
        .o_tail      (queue_tail),
        .o_full      (queue_full),
        .o_empty     (queue_empty)
    );

    // Head slot is offered to the line reader until its line comes back
    assign o_line_req_valid = entry_valid[queue_head];
    assign o_line_req_addr  = entry_addr[queue_head];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_busy    <= 1'b0;
            o_fill_valid <= 1'b0;
        end else begin
            o_fill_valid <= line_pop;
            if (line_pop) begin
                line_busy <= 1'b0;
            end else if (o_line_req_valid && i_line_req_ready) begin
                line_busy <= 1'b1;
            end
        end
    end

    // Fill payload holds the line-aligned address of the retiring head
    always_ff @(posedge clk) begin
        if (line_pop) begin
            o_fill.addr <= {entry_addr[queue_head], {`LINE_OFFSET_WIDTH{1'b0}}};
            o_fill.data <= i_line_data;
        end
    end

endmodule

/* src/ifq_entry.sv */
// Single fetch queue slot holding a pending miss line address, instantiated per slot by ifq
`timescale 1ns/100ps

module ifq_entry (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_alloc_en,
    input  ifq_pkg::line_addr_t i_alloc_addr,
    input  logic               i_clear,
    output logic               o_valid,
    output ifq_pkg::line_addr_t o_addr
);

    // Slot becomes busy on allocation, free once its line is read
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_alloc_en) begin
            o_valid <= 1'b1;
        end else if (i_clear) begin
            o_valid <= 1'b0;
        end
    end

    // Line address captured with the allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            o_addr <= i_alloc_addr;
        end
    end

endmodule

/* src/ifq_pkg.sv */
// Fetch-side types for miss allocation and the instruction cache fill
`include "icache_consts.svh"

package ifq_pkg;

    // Address with the line offset bits stripped
    typedef logic [`ADDR_WIDTH-`LINE_OFFSET_WIDTH-1:0] line_addr_t;

    // Miss allocation from the fetch unit carrying the full byte address
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
    } ifq_alloc_t;

    // Fill to the cache with the line-aligned byte address and the line data
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`LINE_WIDTH-1:0] data;
    } ifq_fill_t;

endpackage

/* src/ifq_queue_ctrl.sv */
// Circular queue pointer control with full and empty flags, used by the fetch queue
`timescale 1ns/100ps

module ifq_queue_ctrl #(
    parameter int DEPTH = 4
) (
    input  logic                                          clk,
    input  logic                                          i_rst_n,
    input  logic                                          i_incr_head,
    input  logic                                          i_incr_tail,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] o_head,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] o_tail,
    output logic                                          o_full,
    output logic                                          o_empty
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_head <= '0;
            o_tail <= '0;
            count  <= '0;
        end else begin
            if (i_incr_head) begin
                o_head <= (o_head == PTR_WIDTH'(DEPTH - 1)) ? '0 : o_head + 1'b1;
            end
            if (i_incr_tail) begin
                o_tail <= (o_tail == PTR_WIDTH'(DEPTH - 1)) ? '0 : o_tail + 1'b1;
            end
            // Push and pop together leave occupancy alone
            if (i_incr_tail && !i_incr_head) begin
                count <= count + 1'b1;
            end else if (i_incr_head && !i_incr_tail) begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_full  = (count == CNT_WIDTH'(DEPTH));
    assign o_empty = (count == '0);

endmodule

/* testbench/icache_miss_unit_chk.sv */
// Protocol assertions for the miss path, bound onto every icache_miss_unit instance
`timescale 1ns/100ps

module icache_miss_unit_chk (
    input logic              clk,
    input logic              i_rst_n,
    input logic              i_mem_req_valid,
    input ccu_pkg::mem_req_t i_mem_req,
    input logic              i_mem_req_ready,
    input logic              i_fill_valid,
    input logic              i_alloc_ready
);

    int assert_errors = 0;

    // A stalled request keeps its valid and its address
    a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_mem_req_valid && !i_mem_req_ready) |=> (i_mem_req_valid && $stable(i_mem_req)))
        else begin
            $error("memory request dropped or changed while stalled");
            assert_errors++;
        end

    // Fill is a single-cycle pulse
    a_fill_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_fill_valid |=> !i_fill_valid)
        else begin
            $error("fill valid held for more than one cycle");
            assert_errors++;
        end

    // Reset values of the outputs once reset has been seen by a clock edge
    a_reset_state: assert property (@(posedge clk)
        (!i_rst_n && $past(!i_rst_n)) |-> (!i_fill_valid && !i_mem_req_valid && i_alloc_ready))
        else begin
            $error("outputs not at their reset values during reset");
            assert_errors++;
        end

endmodule

bind icache_miss_unit icache_miss_unit_chk u_chk (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_mem_req_valid (o_mem_req_valid),
    .i_mem_req       (o_mem_req),
    .i_mem_req_ready (i_mem_req_ready),
    .i_fill_valid    (o_fill_valid),
    .i_alloc_ready   (o_alloc_ready)
);

/* testbench/icache_stimulus.txt */
# alloc_addr(hex) beat_latency(cycles) gap(cycles) fill_addr(hex)
# one allocation per line, fills expected in this order
00001000 1 3 00001000
0000201c 2 0 00002010
00003004 4 0 00003000
0000400c 6 0 00004000
00005008 6 0 00005000
000060f4 6 0 000060f0
00007ffc 3 0 00007ff0
8000000a 1 5 80000000
deadbeef 2 1 deadbee0
00000000 5 0 00000000
ffffffff 3 0 fffffff0
12345678 1 0 12345670
0abcdef4 2 8 0abcdef0
00010010 4 0 00010010

/* testbench/tb_checker.sv */
// Fill scoreboard that tracks accepted allocations and compares every fill in order
`timescale 1ns/100ps
`include "icache_consts.svh"

module tb_checker (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_alloc_valid,
    input  logic                   i_alloc_ready,
    input  logic [`ADDR_WIDTH-1:0] i_exp_addr,
    input  logic                   i_fill_valid,
    input  ifq_pkg::ifq_fill_t     i_fill,
    input  int                     i_num_tests,
    output logic                   o_done,
    output int                     o_fills,
    output int                     o_errors
);

    logic [`ADDR_WIDTH-1:0] exp_q [$];
    int                     pending;

    // Word k of a line is its word address XOR A5A5A5A5
    function automatic logic [`LINE_WIDTH-1:0] expected_line(input logic [`ADDR_WIDTH-1:0] base);
        logic [`LINE_WIDTH-1:0] line;
        line = '0;
        for (int k = 0; k < `LINE_BEATS; k++) begin
            line[k*`WORD_WIDTH +: `WORD_WIDTH] = (base + 4 * k) ^ 32'hA5A5A5A5;
        end
        return line;
    endfunction

    task automatic compare_fill();
        logic [`ADDR_WIDTH-1:0] exp_addr;
        logic [`LINE_WIDTH-1:0] exp_data;
        logic [`WORD_WIDTH-1:0] exp_word;
        logic [`WORD_WIDTH-1:0] got_word;
        int                     test_errs;
        test_errs = 0;
        if (exp_q.size() == 0) begin
            $display("Fill at address %h arrived with no allocation pending", i_fill.addr);
            o_errors++;
            return;
        end
        exp_addr = exp_q.pop_front();
        exp_data = expected_line(exp_addr);
        if (i_fill.addr !== exp_addr) begin
            $display("ERR o_fill.addr expected %h got %h", exp_addr, i_fill.addr);
            test_errs++;
        end
        for (int k = 0; k < `LINE_BEATS; k++) begin
            exp_word = exp_data[k*`WORD_WIDTH +: `WORD_WIDTH];
            got_word = i_fill.data[k*`WORD_WIDTH +: `WORD_WIDTH];
            if (got_word !== exp_word) begin
                $display("ERR o_fill.data[%0d] expected %h got %h", k, exp_word, got_word);
                test_errs++;
            end
        end
        o_errors += test_errs;
        $display("test %0d line %h: %s", o_fills, exp_addr, (test_errs == 0) ? "ok" : "mismatch");
        o_fills++;
    endtask

    // Sampled mid-cycle where DUT outputs and driven inputs are settled
    always @(negedge clk) begin
        if (!i_rst_n) begin
            exp_q.delete();
            pending  = 0;
            o_done   <= 1'b0;
            o_fills  = 0;
            o_errors = 0;
        end else begin
            // Queue frees its slot one cycle before the fill shows
            if (i_alloc_ready !== ((pending - int'(i_fill_valid)) < `IFQ_DEPTH)) begin
                $display("ERR o_alloc_ready expected %h got %h",
                         ((pending - int'(i_fill_valid)) < `IFQ_DEPTH), i_alloc_ready);
                o_errors++;
            end
            if (i_fill_valid === 1'b1) begin
                compare_fill();
                pending--;
            end
            if (i_alloc_valid && i_alloc_ready) begin
                exp_q.push_back(i_exp_addr);
                pending++;
            end
            if (!o_done && o_fills >= i_num_tests) begin
                $display("Checked %0d of %0d fills, %0d errors", o_fills, i_num_tests, o_errors);
                o_done <= 1'b1;
            end
        end
    end

endmodule

/* testbench/tb_clkgen.sv */
// Free-running testbench clock source, instantiated once by the testbench top
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

/* testbench/tb_icache_miss_unit.sv */
// Testbench top that reads the stimulus file, drives allocations, models memory and guards the run
`timescale 1ns/100ps
`include "icache_consts.svh"

module tb_icache_miss_unit;

    localparam int MAX_TESTS = 64;

    logic                   clk;
    logic                   i_rst_n;
    logic                   i_alloc_valid;
    ifq_pkg::ifq_alloc_t    i_alloc;
    logic                   o_alloc_ready;
    logic                   o_fill_valid;
    ifq_pkg::ifq_fill_t     o_fill;
    logic                   o_mem_req_valid;
    ccu_pkg::mem_req_t      o_mem_req;
    logic                   i_mem_req_ready;
    logic                   i_mem_rsp_valid;
    ccu_pkg::mem_rsp_t      i_mem_rsp;
    logic [`ADDR_WIDTH-1:0] exp_addr;

    logic [`ADDR_WIDTH-1:0] stim_addr [MAX_TESTS];
    logic [`ADDR_WIDTH-1:0] stim_exp [MAX_TESTS];
    int                     stim_lat [MAX_TESTS];
    int                     stim_gap [MAX_TESTS];
    int                     num_tests = 0;
    int                     watchdog_cycles = 0;
    integer                 seed = 15167;
    logic                   checker_done;
    int                     checker_fills;
    int                     checker_errors;

    tb_clkgen #(.PERIOD_NS(20)) u_clkgen (.o_clk(clk));

    icache_miss_unit dut (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_alloc_valid   (i_alloc_valid),
        .i_alloc         (i_alloc),
        .o_alloc_ready   (o_alloc_ready),
        .o_fill_valid    (o_fill_valid),
        .o_fill          (o_fill),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_req       (o_mem_req),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp       (i_mem_rsp)
    );

    tb_checker u_checker (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_alloc_valid (i_alloc_valid),
        .i_alloc_ready (o_alloc_ready),
        .i_exp_addr    (exp_addr),
        .i_fill_valid  (o_fill_valid),
        .i_fill        (o_fill),
        .i_num_tests   (num_tests),
        .o_done        (checker_done),
        .o_fills       (checker_fills),
        .o_errors      (checker_errors)
    );

    // Lines that do not parse as four fields are comments
    task automatic load_stimulus();
        int                     fd;
        int                     code;
        logic [8*96-1:0]        text;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`ADDR_WIDTH-1:0] line_addr;
        int                     lat;
        int                     gap;
        fd = $fopen("testbench/icache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file testbench/icache_stimulus.txt");
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                code = $fgets(text, fd);
                if (code > 0 && $sscanf(text, "%h %d %d %h", addr, lat, gap, line_addr) == 4) begin
                    stim_addr[num_tests] = addr;
                    stim_lat[num_tests]  = (lat < 1) ? 1 : lat;
                    stim_gap[num_tests]  = gap;
                    stim_exp[num_tests]  = line_addr;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_alloc(input int idx);
        i_alloc_valid = 1'b1;
        i_alloc.addr  = stim_addr[idx];
        exp_addr      = stim_exp[idx];
        while (o_alloc_ready !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        i_alloc_valid = 1'b0;
        repeat (stim_gap[idx]) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin : main
        int max_span;
        i_rst_n       = 1'b0;
        i_alloc_valid = 1'b0;
        i_alloc       = '0;
        exp_addr      = '0;
        load_stimulus();
        if (num_tests == 0) begin
            $display("No tests were loaded from the stimulus file");
            $display("=== FAIL ===");
            $finish;
        end else begin
            max_span = 1;
            for (int i = 0; i < num_tests; i++) begin
                if (stim_lat[i] + stim_gap[i] > max_span) begin
                    max_span = stim_lat[i] + stim_gap[i];
                end
            end
            watchdog_cycles = num_tests * max_span * 10 + 5;
            repeat (5) @(posedge clk);
            #2;
            i_rst_n = 1'b1;
            for (int i = 0; i < num_tests; i++) begin
                drive_alloc(i);
            end
            wait (checker_done === 1'b1);
            // Idle tail catches any stray extra fill
            repeat (20) @(posedge clk);
            if (checker_errors == 0 && dut.u_chk.assert_errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

    // Memory model stalls ready briefly, then answers each beat after the line's latency
    initial begin : memory_model
        integer                 beats_done;
        int                     stall;
        int                     line_idx;
        logic [`ADDR_WIDTH-1:0] word_addr;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp       = '0;
        beats_done      = 0;
        wait (i_rst_n === 1'b1);
        forever begin
            while (o_mem_req_valid !== 1'b1) begin
                @(posedge clk);
                #2;
            end
            stall = $unsigned($random(seed)) % 3;
            repeat (stall) begin
                @(posedge clk);
                #2;
            end
            i_mem_req_ready = 1'b1;
            word_addr       = o_mem_req.addr;
            @(posedge clk);
            #2;
            i_mem_req_ready = 1'b0;
            line_idx = (beats_done / `LINE_BEATS) % MAX_TESTS;
            repeat (stim_lat[line_idx] - 1) begin
                @(posedge clk);
                #2;
            end
            i_mem_rsp_valid = 1'b1;
            i_mem_rsp.data  = word_addr ^ 32'hA5A5A5A5;
            @(posedge clk);
            #2;
            i_mem_rsp_valid = 1'b0;
            beats_done++;
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, fills are missing: %0d of %0d arrived",
                 watchdog_cycles, checker_fills, num_tests);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
